//--- serial_pkg.sv
package serial_pkg;

   localparam int XLEN   = 32;
   localparam int REG_AW = 5;
   localparam int CNT_W  = 5;

   localparam logic [6:0] OP_IMM = 7'b0010011;
   localparam logic [6:0] OP_REG = 7'b0110011;
   localparam logic [6:0] OP_LUI = 7'b0110111;

   localparam logic [2:0] F3_ADD = 3'b000;
   localparam logic [2:0] F3_XOR = 3'b100;
   localparam logic [2:0] F3_OR  = 3'b110;
   localparam logic [2:0] F3_AND = 3'b111;

   typedef struct packed {
      logic [6:0] funct7;
      logic [4:0] rs2;
      logic [4:0] rs1;
      logic [2:0] funct3;
      logic [4:0] rd;
      logic [6:0] opcode;
   } r_type_t;

   typedef struct packed {
      logic [11:0] imm12;
      logic [4:0]  rs1;
      logic [2:0]  funct3;
      logic [4:0]  rd;
      logic [6:0]  opcode;
   } i_type_t;

   typedef struct packed {
      logic [19:0] imm20;
      logic [4:0]  rd;
      logic [6:0]  opcode;
   } u_type_t;

   typedef union packed {
      r_type_t r;
      i_type_t i;
      u_type_t u;
   } instr_t;

   // Same as funct3[1:0] of the boolean ops
   typedef logic [1:0] bool_op_t;
   localparam bool_op_t BOOL_XOR = 2'b00;
   localparam bool_op_t BOOL_OR  = 2'b10;
   localparam bool_op_t BOOL_AND = 2'b11;

   localparam logic [1:0] RD_SUM  = 2'd0;
   localparam logic [1:0] RD_BOOL = 2'd1;
   localparam logic [1:0] RD_IMM  = 2'd2;

   typedef struct packed {
      logic       sub;
      bool_op_t   bool_op;
      logic [1:0] rd_sel;
      logic       op_b_imm;
   } alu_ctrl_t;

endpackage

//--- serial_state.sv
`timescale 1ns/1ps
`default_nettype none

module serial_state
   import serial_pkg::*;
   (
   input  logic clk,
   input  logic i_rst_n,
   input  logic i_ibus_ack,
   input  logic i_rf_ready,
   input  logic i_rd_wen,
   output logic o_ibus_cyc,
   output logic o_rf_rreq,
   output logic o_cnt_en,
   output logic o_cnt_done,
   output logic o_wen0);

   logic [CNT_W-1:0] cnt;
   logic             ibus_cyc;
   logic             rf_rreq;
   logic             rf_wait;
   logic             cnt_en;
   logic             idle;
   logic             rf_pending;

   // Nothing in flight, start a new fetch
   assign idle       = !(ibus_cyc | rf_rreq | rf_wait | cnt_en);
   assign rf_pending = rf_rreq | rf_wait;

   assign o_cnt_done = cnt_en & (cnt == {CNT_W{1'b1}});

   always_ff @(posedge clk) begin
      if (!i_rst_n) begin
         ibus_cyc <= 1'b0;
         rf_rreq  <= 1'b0;
         rf_wait  <= 1'b0;
         cnt_en   <= 1'b0;
         cnt      <= '0;
      end else begin
         if (ibus_cyc & i_ibus_ack)
            ibus_cyc <= 1'b0;
         else if (o_cnt_done | idle)
            ibus_cyc <= 1'b1;

         rf_rreq <= ibus_cyc & i_ibus_ack;

         // Ready may come in the request cycle or any time later
         rf_wait <= rf_pending & !i_rf_ready;

         if (rf_pending & i_rf_ready)
            cnt_en <= 1'b1;
         else if (o_cnt_done)
            cnt_en <= 1'b0;

         if (cnt_en)
            cnt <= cnt + 1'b1;
      end
   end

   assign o_ibus_cyc = ibus_cyc;
   assign o_rf_rreq  = rf_rreq;
   assign o_cnt_en   = cnt_en;
   assign o_wen0     = cnt_en & i_rd_wen;

endmodule
`default_nettype wire

//--- serial_decode.sv
`timescale 1ns/1ps
`default_nettype none

module serial_decode
   import serial_pkg::*;
   (
   input  logic              clk,
   input  logic              i_ibus_ack,
   input  instr_t            i_ibus_rdt,
   output alu_ctrl_t         o_alu_ctrl,
   output logic              o_rd_wen,
   output logic [REG_AW-1:0] o_rs1_addr,
   output logic [REG_AW-1:0] o_rs2_addr,
   output logic [REG_AW-1:0] o_rd_addr);

   instr_t     ir;
   logic       is_imm;
   logic       is_reg;
   logic       is_lui;
   logic       f3_ok;
   logic       op_ok;
   logic [2:0] funct3;

   always_ff @(posedge clk) begin
      if (i_ibus_ack)
         ir <= i_ibus_rdt;
   end

   assign is_imm = (ir.r.opcode == OP_IMM);
   assign is_reg = (ir.r.opcode == OP_REG);
   assign is_lui = (ir.u.opcode == OP_LUI);
   assign funct3 = ir.r.funct3;

   // Only add and the three boolean ops are kept
   assign f3_ok = (funct3 == F3_ADD) | (funct3 == F3_XOR) |
                  (funct3 == F3_OR)  | (funct3 == F3_AND);
   assign op_ok = is_lui | ((is_imm | is_reg) & f3_ok);

   always_comb begin
      o_alu_ctrl.sub      = is_reg & ir.r.funct7[5];
      o_alu_ctrl.bool_op  = funct3[1:0];
      o_alu_ctrl.op_b_imm = !is_reg;
      if (is_lui)
         o_alu_ctrl.rd_sel = RD_IMM;
      else if (funct3 == F3_ADD)
         o_alu_ctrl.rd_sel = RD_SUM;
      else
         o_alu_ctrl.rd_sel = RD_BOOL;
   end

   // x0 is never written
   assign o_rd_wen = op_ok & (ir.r.rd != '0);

   assign o_rs1_addr = ir.i.rs1;
   assign o_rs2_addr = ir.r.rs2;
   assign o_rd_addr  = ir.r.rd;

endmodule
`default_nettype wire

//--- serial_immdec.sv
`timescale 1ns/1ps
`default_nettype none

module serial_immdec
   import serial_pkg::*;
   (
   input  logic   clk,
   input  logic   i_ibus_ack,
   input  instr_t i_ibus_rdt,
   input  logic   i_cnt_en,
   output logic   o_imm);

   logic [XLEN-1:0] imm_sr;
   logic [XLEN-1:0] imm_i;
   logic [XLEN-1:0] imm_u;

   assign imm_i = {{(XLEN-12){i_ibus_rdt.i.imm12[11]}}, i_ibus_rdt.i.imm12};
   assign imm_u = {i_ibus_rdt.u.imm20, 12'b0};

   always_ff @(posedge clk) begin
      if (i_ibus_ack) begin
         if (i_ibus_rdt.u.opcode == OP_LUI)
            imm_sr <= imm_u;
         else
            imm_sr <= imm_i;
      end else if (i_cnt_en) begin
         // LSB first
         imm_sr <= {imm_sr[XLEN-1], imm_sr[XLEN-1:1]};
      end
   end

   assign o_imm = imm_sr[0];

endmodule
`default_nettype wire

//--- serial_alu.sv
`timescale 1ns/1ps
`default_nettype none

module serial_alu
   import serial_pkg::*;
   (
   input  logic      clk,
   input  logic      i_cnt_en,
   input  logic      i_cnt_done,
   input  alu_ctrl_t i_ctrl,
   input  logic      i_rs1,
   input  logic      i_rs2,
   input  logic      i_imm,
   output logic      o_rd);

   logic cy_r;
   logic mid_r;
   logic op_b;
   logic b_inv;
   logic cy_in;
   logic cy_out;
   logic sum;
   logic bool_res;

   assign op_b  = i_ctrl.op_b_imm ? i_imm : i_rs2;
   assign b_inv = op_b ^ i_ctrl.sub;

   // Subtract as rs1 + ~b + 1, the +1 enters at bit 0
   assign cy_in = mid_r ? cy_r : i_ctrl.sub;
   assign {cy_out, sum} = {1'b0, i_rs1} + {1'b0, b_inv} + {1'b0, cy_in};

   always_ff @(posedge clk) begin
      mid_r <= i_cnt_en & !i_cnt_done;
      cy_r  <= i_cnt_en & !i_cnt_done & cy_out;
   end

   always_comb begin
      case (i_ctrl.bool_op)
         BOOL_OR:  bool_res = i_rs1 | op_b;
         BOOL_AND: bool_res = i_rs1 & op_b;
         default:  bool_res = i_rs1 ^ op_b;
      endcase
   end

   always_comb begin
      case (i_ctrl.rd_sel)
         RD_BOOL: o_rd = bool_res;
         RD_IMM:  o_rd = i_imm;
         default: o_rd = sum;
      endcase
   end

endmodule
`default_nettype wire

//--- serial_pc.sv
`timescale 1ns/1ps
`default_nettype none

module serial_pc
   import serial_pkg::*;
   #(parameter logic [XLEN-1:0] RESET_PC = 32'd0)
   (
   input  logic            clk,
   input  logic            i_rst_n,
   input  logic            i_cnt_done,
   output logic [XLEN-1:0] o_ibus_adr);

   logic [XLEN-1:0] pc;
   logic [XLEN-1:0] pc_next;

   // Only sequential flow, so one parallel add per instruction
   assign pc_next = pc + 32'd4;

   always_ff @(posedge clk) begin
      if (!i_rst_n)
         pc <= RESET_PC;
      else if (i_cnt_done)
         pc <= pc_next;
   end

   assign o_ibus_adr = pc;

endmodule
`default_nettype wire

//--- serial_cpu_top.sv
`timescale 1ns/1ps
`default_nettype none

module serial_cpu_top
   import serial_pkg::*;
   #(parameter logic [XLEN-1:0] RESET_PC = 32'd0)
   (
   input  logic              clk,
   input  logic              i_rst_n,
   // Instruction bus
   output logic [XLEN-1:0]   o_ibus_adr,
   output logic              o_ibus_cyc,
   input  logic [XLEN-1:0]   i_ibus_rdt,
   input  logic              i_ibus_ack,
   // Register file
   output logic              o_rf_rreq,
   input  logic              i_rf_ready,
   output logic [REG_AW-1:0] o_rreg0,
   output logic [REG_AW-1:0] o_rreg1,
   input  logic              i_rdata0,
   input  logic              i_rdata1,
   output logic              o_wen0,
   output logic [REG_AW-1:0] o_wreg0,
   output logic              o_wdata0);

   alu_ctrl_t alu_ctrl;
   logic      rd_wen;
   logic      cnt_en;
   logic      cnt_done;
   logic      imm;

   serial_state state (
      .clk        (clk),
      .i_rst_n    (i_rst_n),
      .i_ibus_ack (i_ibus_ack),
      .i_rf_ready (i_rf_ready),
      .i_rd_wen   (rd_wen),
      .o_ibus_cyc (o_ibus_cyc),
      .o_rf_rreq  (o_rf_rreq),
      .o_cnt_en   (cnt_en),
      .o_cnt_done (cnt_done),
      .o_wen0     (o_wen0));

   serial_decode decode (
      .clk        (clk),
      .i_ibus_ack (i_ibus_ack),
      .i_ibus_rdt (i_ibus_rdt),
      .o_alu_ctrl (alu_ctrl),
      .o_rd_wen   (rd_wen),
      .o_rs1_addr (o_rreg0),
      .o_rs2_addr (o_rreg1),
      .o_rd_addr  (o_wreg0));

   serial_immdec immdec (
      .clk        (clk),
      .i_ibus_ack (i_ibus_ack),
      .i_ibus_rdt (i_ibus_rdt),
      .i_cnt_en   (cnt_en),
      .o_imm      (imm));

   serial_alu alu (
      .clk        (clk),
      .i_cnt_en   (cnt_en),
      .i_cnt_done (cnt_done),
      .i_ctrl     (alu_ctrl),
      .i_rs1      (i_rdata0),
      .i_rs2      (i_rdata1),
      .i_imm      (imm),
      .o_rd       (o_wdata0));

   serial_pc #(.RESET_PC (RESET_PC)) pc (
      .clk        (clk),
      .i_rst_n    (i_rst_n),
      .i_cnt_done (cnt_done),
      .o_ibus_adr (o_ibus_adr));

endmodule
`default_nettype wire

//--- serial_cpu_sva.sv
`timescale 1ns/1ps

module serial_cpu_sva (
   input logic clk,
   input logic i_rst_n,
   input logic i_ibus_cyc,
   input logic i_rf_rreq,
   input logic i_wen0);

   logic rst_q;
   int   fail_count = 0;

   // Set from the second reset cycle on
   always_ff @(posedge clk)
      rst_q <= !i_rst_n;

   rreq_single: assert property (@(posedge clk) disable iff (!i_rst_n)
      i_rf_rreq |=> !i_rf_rreq)
      else begin
         fail_count = fail_count + 1;
         $error("o_rf_rreq held for more than one cycle");
      end

   cyc_wen_apart: assert property (@(posedge clk) disable iff (!i_rst_n)
      !(i_ibus_cyc && i_wen0))
      else begin
         fail_count = fail_count + 1;
         $error("o_ibus_cyc and o_wen0 high in the same cycle");
      end

   quiet_in_reset: assert property (@(posedge clk)
      (!i_rst_n && rst_q) |-> !(i_ibus_cyc || i_rf_rreq || i_wen0))
      else begin
         fail_count = fail_count + 1;
         $error("Bus or register file strobe active during reset");
      end

endmodule

bind serial_cpu_top serial_cpu_sva sva (
   .clk        (clk),
   .i_rst_n    (i_rst_n),
   .i_ibus_cyc (o_ibus_cyc),
   .i_rf_rreq  (o_rf_rreq),
   .i_wen0     (o_wen0));

//--- serial_cpu_tb.sv
`timescale 1ns/1ps

module serial_cpu_tb
   import serial_pkg::*;
   ();

   localparam int          CLK_PERIOD = 8;
   localparam logic [31:0] RESET_PC   = 32'h0000_0040;
   localparam int          PROG_LEN   = 48;
   localparam int          IMEM_WORDS = 128;
   localparam logic [6:0]  OP_BRANCH  = 7'b1100011;

   logic        clk;
   logic        i_rst_n;
   logic [31:0] i_ibus_rdt;
   logic        i_ibus_ack;
   logic        i_rf_ready;
   logic        i_rdata0;
   logic        i_rdata1;
   logic [31:0] o_ibus_adr;
   logic        o_ibus_cyc;
   logic        o_rf_rreq;
   logic [4:0]  o_rreg0;
   logic [4:0]  o_rreg1;
   logic        o_wen0;
   logic [4:0]  o_wreg0;
   logic        o_wdata0;

   int          seed;
   logic [31:0] imem [0:IMEM_WORDS-1];
   logic [31:0] regs [0:31];
   logic [31:0] exp_regs [0:31];
   logic [31:0] pc_exp;
   logic [31:0] cmp_word;
   logic [31:0] cmp_a;
   logic [31:0] cmp_b;
   logic [31:0] wen_bits;
   logic [31:0] got_data;
   logic [32:0] ref_out;
   event        instr_end;

   initial clk = 1'b0;
   always #(CLK_PERIOD / 2) clk = ~clk;

   serial_cpu_top #(.RESET_PC (RESET_PC)) dut (
      .clk        (clk),
      .i_rst_n    (i_rst_n),
      .o_ibus_adr (o_ibus_adr),
      .o_ibus_cyc (o_ibus_cyc),
      .i_ibus_rdt (i_ibus_rdt),
      .i_ibus_ack (i_ibus_ack),
      .o_rf_rreq  (o_rf_rreq),
      .i_rf_ready (i_rf_ready),
      .o_rreg0    (o_rreg0),
      .o_rreg1    (o_rreg1),
      .i_rdata0   (i_rdata0),
      .i_rdata1   (i_rdata1),
      .o_wen0     (o_wen0),
      .o_wreg0    (o_wreg0),
      .o_wdata0   (o_wdata0));

   task automatic abort_run(input string why);
      $display("%s", why);
      $display("Result: FAILED");
      $fatal(1);
   endtask

   task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
      if (got !== exp)
         abort_run($sformatf("Fail time=%0t %s got=%h exp=%h", $time, name, got, exp));
   endtask

   function automatic int rand_below(input int n);
      logic [31:0] r;
      r = $random(seed);
      return int'(r % n);
   endfunction

   // Expected {write flag, result} for one instruction word
   function automatic logic [32:0] ref_result(input logic [31:0] w, input logic [31:0] a,
                                              input logic [31:0] b);
      logic [6:0]  op;
      logic [2:0]  f3;
      logic [31:0] opb;
      logic [31:0] y;
      logic        ok;
      op  = w[6:0];
      f3  = w[14:12];
      opb = (op == OP_REG) ? b : {{20{w[31]}}, w[31:20]};
      ok  = 1'b1;
      y   = 32'd0;
      if (op == OP_LUI) begin
         y = {w[31:12], 12'd0};
      end else if (op == OP_IMM || op == OP_REG) begin
         case (f3)
            F3_ADD:  y = (op == OP_REG && w[30]) ? a - opb : a + opb;
            F3_XOR:  y = a ^ opb;
            F3_OR:   y = a | opb;
            F3_AND:  y = a & opb;
            default: ok = 1'b0;
         endcase
      end else begin
         ok = 1'b0;
      end
      return {ok && (w[11:7] != 5'd0), y};
   endfunction

   task automatic build_program();
      int          base;
      logic [4:0]  rd;
      logic [4:0]  rs1;
      logic [4:0]  rs2;
      logic [11:0] imm;
      base = int'(RESET_PC >> 2);
      // Borrow through all 32 bits, then LUI, then a write to x0
      imem[base]     = {12'd1, 5'd0, F3_ADD, 5'd1, OP_IMM};
      imem[base + 1] = {7'b0100000, 5'd1, 5'd0, F3_ADD, 5'd2, OP_REG};
      imem[base + 2] = {20'hABCDE, 5'd3, OP_LUI};
      imem[base + 3] = {12'h7FF, 5'd2, F3_ADD, 5'd0, OP_IMM};
      for (int n = 4; n < PROG_LEN; n++) begin
         rd  = 5'(rand_below(32));
         rs1 = 5'(rand_below(32));
         rs2 = 5'(rand_below(32));
         imm = 12'($random(seed));
         case (rand_below(12))
            0:  imem[base + n] = {imm, rs1, F3_ADD, rd, OP_IMM};
            1:  imem[base + n] = {imm, rs1, F3_XOR, rd, OP_IMM};
            2:  imem[base + n] = {imm, rs1, F3_OR, rd, OP_IMM};
            3:  imem[base + n] = {imm, rs1, F3_AND, rd, OP_IMM};
            4:  imem[base + n] = {7'd0, rs2, rs1, F3_ADD, rd, OP_REG};
            5:  imem[base + n] = {7'b0100000, rs2, rs1, F3_ADD, rd, OP_REG};
            6:  imem[base + n] = {7'd0, rs2, rs1, F3_XOR, rd, OP_REG};
            7:  imem[base + n] = {7'd0, rs2, rs1, F3_OR, rd, OP_REG};
            8:  imem[base + n] = {7'd0, rs2, rs1, F3_AND, rd, OP_REG};
            9:  imem[base + n] = {20'($random(seed)), rd, OP_LUI};
            10: imem[base + n] = {7'd0, rs2, rs1, 3'b000, rd, OP_BRANCH};
            default: imem[base + n] = {7'd0, rs2, rs1, 3'b001, rd, OP_IMM};
         endcase
      end
   endtask

   // One instruction from fetch to the last counted cycle
   task automatic run_instr();
      logic [31:0] word;
      logic [6:0]  iaddr;
      int          delay;
      @(negedge clk);
      check("o_ibus_cyc", 32'(o_ibus_cyc), 32'd1);
      check("o_ibus_adr", o_ibus_adr, pc_exp);
      iaddr = o_ibus_adr[8:2];
      word  = imem[iaddr];
      delay = rand_below(4);
      repeat (delay) begin
         check("o_wen0", 32'(o_wen0), 32'd0);
         @(negedge clk);
         check("o_ibus_cyc", 32'(o_ibus_cyc), 32'd1);
      end
      i_ibus_rdt = word;
      i_ibus_ack = 1'b1;
      @(negedge clk);
      i_ibus_ack = 1'b0;
      i_ibus_rdt = $random(seed);
      check("o_rf_rreq", 32'(o_rf_rreq), 32'd1);
      check("o_ibus_cyc", 32'(o_ibus_cyc), 32'd0);
      check("o_rreg0", 32'(o_rreg0), 32'(word[19:15]));
      check("o_rreg1", 32'(o_rreg1), 32'(word[24:20]));
      delay = rand_below(4);
      repeat (delay) begin
         check("o_wen0", 32'(o_wen0), 32'd0);
         @(negedge clk);
      end
      check("o_wen0", 32'(o_wen0), 32'd0);
      i_rf_ready = 1'b1;
      cmp_word   = word;
      cmp_a      = regs[word[19:15]];
      cmp_b      = regs[word[24:20]];
      for (int k = 0; k < 32; k++) begin
         @(negedge clk);
         i_rf_ready = 1'b0;
         i_rdata0   = cmp_a[k];
         i_rdata1   = cmp_b[k];
         #1;
         wen_bits[k] = o_wen0;
         got_data[k] = o_wdata0;
         if (o_wen0)
            check("o_wreg0", 32'(o_wreg0), 32'(word[11:7]));
      end
      // Register file model commits the collected bits unless rd is x0
      if (wen_bits != 32'd0 && word[11:7] != 5'd0)
         regs[word[11:7]] = got_data;
      pc_exp = pc_exp + 32'd4;
      -> instr_end;
   endtask

   always @(instr_end) begin
      ref_out = ref_result(cmp_word, cmp_a, cmp_b);
      check("o_wen0", wen_bits, {32{ref_out[32]}});
      if (ref_out[32]) begin
         check("o_wdata0", got_data, ref_out[31:0]);
         exp_regs[cmp_word[11:7]] = ref_out[31:0];
      end
   end

   // A failed bound assertion ends the run at once
   always @(dut.sva.fail_count) begin
      if (dut.sva.fail_count != 0)
         abort_run("A bound assertion on the bus or register file strobes failed");
   end

   initial begin
      repeat (PROG_LEN * 200 + 8) @(posedge clk);
      abort_run("Watchdog timeout, the core stopped finishing instructions");
   end

   initial begin
      seed       = 31807;
      i_rst_n    = 1'b0;
      i_ibus_rdt = 32'd0;
      i_ibus_ack = 1'b0;
      i_rf_ready = 1'b0;
      i_rdata0   = 1'b0;
      i_rdata1   = 1'b0;
      // Unused words decode as branches carrying their own index
      for (int i = 0; i < IMEM_WORDS; i++)
         imem[i] = {25'(i), OP_BRANCH};
      regs[0]     = 32'd0;
      exp_regs[0] = 32'd0;
      for (int i = 1; i < 32; i++) begin
         regs[i]     = $random(seed);
         exp_regs[i] = regs[i];
      end
      build_program();
      pc_exp = RESET_PC;
      repeat (8) @(posedge clk);
      @(negedge clk);
      i_rst_n = 1'b1;
      for (int n = 0; n < PROG_LEN; n++)
         run_instr();
      @(negedge clk);
      check("o_ibus_cyc", 32'(o_ibus_cyc), 32'd1);
      check("o_ibus_adr", o_ibus_adr, pc_exp);
      for (int r = 0; r < 32; r++)
         check($sformatf("x%0d", r), regs[r], exp_regs[r]);
      $display("Result: PASSED");
      $finish;
   end

endmodule

//--- serial_cpu_top.f
serial_pkg.sv
serial_state.sv
serial_decode.sv
serial_immdec.sv
serial_alu.sv
serial_pc.sv
serial_cpu_top.sv
serial_cpu_sva.sv
serial_cpu_tb.sv

//--- Makefile
SIM      = verilator
FLAGS    = --binary --timing --assert
TOP      = serial_cpu_tb
FILELIST = serial_cpu_top.f

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build and run the simulation with $(SIM)"
	@echo "  clean  remove the build output"

test:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir
